//--- verilog/tx_buffer_pkg.sv
/*
  Shared types for the double-buffered transmit packet buffer.
  Words are 64 bits, big-endian byte order within a word.
*/
`default_nettype none

package tx_buffer_pkg;

  // ------------------------------------------------------------
  // Data types
  // ------------------------------------------------------------

  typedef logic [63:0] word_t;
  typedef logic [15:0] sum_t;

  // Valid bytes in the last word, 0 to 8
  typedef logic [3:0] bytes_last_t;

  // ------------------------------------------------------------
  // Byte constants
  // ------------------------------------------------------------

  localparam int BYTES_PER_WORD = 8;

  // Byte address bits below the word address
  localparam int BYTE_SHIFT = 3;

  // ------------------------------------------------------------
  // Bank state and status records
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    BANK_EMPTY    = 2'd0,
    BANK_HAS_DATA = 2'd1,
    BANK_CHECKSUM = 2'd2,
    BANK_FIFO_OUT = 2'd3
  } bank_state_e;

  typedef struct packed {
    logic        available;
    logic        empty;
    bytes_last_t bytes_last;
  } tx_status_t;

  typedef struct packed {
    sum_t sum;
    logic done;
  } sum_result_t;

endpackage

`default_nettype wire

//--- verilog/tx_word_ram.sv
/*
  Single-port bank RAM with registered read data.
  Read during write of the same address returns the old word.
*/
`timescale 1ns/10ps
`default_nettype none

module tx_word_ram
  import tx_buffer_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                  i_clk,
  input  wire                  i_we,
  input  wire [ADDR_WIDTH-1:0] i_addr,
  input  wire word_t           i_wdata,
  output word_t                o_rdata
);

  word_t mem [2**ADDR_WIDTH];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
    // Data for the presented address shows up next cycle
    o_rdata <= mem[i_addr];
  end

endmodule

`default_nettype wire

//--- verilog/tx_bank_ctrl.sv
/*
  Ping-pong bank control. Parser writes always append at the bank pointer.
  Sum addresses must be word aligned. A bank holds at most 2**ADDR_WIDTH-1 words.
*/
`timescale 1ns/10ps
`default_nettype none

module tx_bank_ctrl
  import tx_buffer_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                    i_clk,
  input  wire                    i_areset,
  input  wire                    i_write_en,
  input  wire word_t             i_write_data,
  input  wire                    i_update_length,
  input  wire [ADDR_WIDTH+2:0]   i_length_bytes,
  input  wire                    i_sum_en,
  input  wire [ADDR_WIDTH+2:0]   i_sum_addr,
  input  wire [ADDR_WIDTH+2:0]   i_sum_bytes,
  input  wire                    i_parser_done,
  input  wire                    i_parser_clear,
  input  wire                    i_tx_rd_en,
  input  wire                    i_tx_packet_read,
  input  wire [ADDR_WIDTH-1:0]   i_csum_addr,
  input  wire                    i_csum_reading,
  input  wire word_t             i_rdata0,
  input  wire word_t             i_rdata1,
  output logic                   o_we0,
  output logic                   o_we1,
  output logic [ADDR_WIDTH-1:0]  o_addr0,
  output logic [ADDR_WIDTH-1:0]  o_addr1,
  output word_t                  o_wdata,
  output logic                   o_sum_start,
  output logic [ADDR_WIDTH-1:0]  o_sum_word_addr,
  output logic [ADDR_WIDTH+2:0]  o_sum_bytes,
  output word_t                  o_parser_rdata,
  output logic                   o_parser_full,
  output logic                   o_parser_empty,
  output tx_status_t             o_tx_status,
  output word_t                  o_tx_rd_data,
  output logic                   o_error
);

  bank_state_e           state_q [2];
  bank_state_e           state_d [2];
  logic [ADDR_WIDTH-1:0] ptr_q   [2];
  logic [ADDR_WIDTH-1:0] ptr_d   [2];
  logic [ADDR_WIDTH:0]   wcnt_q  [2];
  logic [ADDR_WIDTH:0]   wcnt_d  [2];
  bytes_last_t           blast_q [2];
  bytes_last_t           blast_d [2];
  logic                  sel_q, sel_d;
  logic                  err_q;

  logic                  p, d;
  logic                  wr_accept;
  logic                  avail, drained, rd_advance;
  logic [ADDR_WIDTH+3:0] len_round;
  logic [ADDR_WIDTH:0]   len_words;
  bytes_last_t           len_last;
  logic [ADDR_WIDTH-1:0] addr [2];
  logic                  we   [2];

  // Parser bank and dispatch bank
  assign p = sel_q;
  assign d = ~sel_q;

  assign o_parser_full = (state_q[p] == BANK_CHECKSUM) || (state_q[p] == BANK_FIFO_OUT) ||
                         (ptr_q[p] == '1);
  assign o_parser_empty = (state_q[p] == BANK_EMPTY);

  assign wr_accept = i_write_en && !i_parser_clear && !o_parser_full;

  assign o_sum_start     = i_sum_en && !i_parser_clear && (state_q[p] == BANK_HAS_DATA);
  assign o_sum_word_addr = i_sum_addr[ADDR_WIDTH+BYTE_SHIFT-1:BYTE_SHIFT];
  assign o_sum_bytes     = i_sum_bytes;

  // Length in words rounded up, remainder gives the last-word byte count
  assign len_round = {1'b0, i_length_bytes} + (ADDR_WIDTH+4)'(BYTES_PER_WORD - 1);
  assign len_words = len_round[ADDR_WIDTH+3:BYTE_SHIFT];
  assign len_last  = (i_length_bytes[BYTE_SHIFT-1:0] != '0) ?
                     {1'b0, i_length_bytes[BYTE_SHIFT-1:0]} :
                     ((i_length_bytes != '0) ? bytes_last_t'(BYTES_PER_WORD) : '0);

  // ------------------------------------------------------------
  // Dispatch status
  // ------------------------------------------------------------

  assign avail      = (state_q[d] == BANK_FIFO_OUT);
  assign drained    = avail && ({1'b0, ptr_q[d]} == wcnt_q[d]);
  assign rd_advance = avail && !drained && i_tx_rd_en && !i_tx_packet_read;

  assign o_tx_status.available  = avail;
  assign o_tx_status.empty      = drained;
  assign o_tx_status.bytes_last = blast_q[d];

  assign o_tx_rd_data   = d ? i_rdata1 : i_rdata0;
  assign o_parser_rdata = p ? i_rdata1 : i_rdata0;
  assign o_error        = err_q;

  // ------------------------------------------------------------
  // Next state for both banks
  // ------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    ptr_d   = ptr_q;
    wcnt_d  = wcnt_q;
    blast_d = blast_q;
    sel_d   = sel_q;

    if (i_parser_clear) begin
      state_d[p] = BANK_EMPTY;
      ptr_d[p]   = '0;
      wcnt_d[p]  = '0;
      blast_d[p] = '0;
    end else begin
      case (state_q[p])
        BANK_EMPTY, BANK_HAS_DATA: begin
          if (wr_accept) begin
            state_d[p] = BANK_HAS_DATA;
            ptr_d[p]   = ptr_q[p] + 1'b1;
            // Until a length arrives the packet is all written words
            wcnt_d[p]  = {1'b0, ptr_q[p]} + 1'b1;
            blast_d[p] = bytes_last_t'(BYTES_PER_WORD);
          end
          if (state_q[p] == BANK_HAS_DATA) begin
            if (i_update_length) begin
              wcnt_d[p]  = len_words;
              blast_d[p] = len_last;
            end
            if (o_sum_start) state_d[p] = BANK_CHECKSUM;
            if (i_parser_done) state_d[p] = BANK_FIFO_OUT;
          end
        end
        BANK_CHECKSUM: begin
          if (!i_csum_reading) state_d[p] = BANK_HAS_DATA;
        end
        default: begin
          // FIFO_OUT waits for the dispatcher to free the other bank
          if (state_q[d] == BANK_EMPTY) begin
            sel_d    = ~sel_q;
            ptr_d[p] = '0;
          end
        end
      endcase
    end

    if (avail) begin
      if (i_tx_packet_read) begin
        state_d[d] = BANK_EMPTY;
        ptr_d[d]   = '0;
        wcnt_d[d]  = '0;
        blast_d[d] = '0;
      end else if (rd_advance) begin
        ptr_d[d] = ptr_q[d] + 1'b1;
      end
    end
  end

  // RAM ports; dispatch reads show ahead by one on an advance
  always_comb begin
    addr[0] = ptr_q[0];
    addr[1] = ptr_q[1];
    we[0]   = 1'b0;
    we[1]   = 1'b0;
    case (state_q[p])
      BANK_CHECKSUM: addr[p] = i_csum_addr;
      BANK_FIFO_OUT: addr[p] = '0;
      default:       addr[p] = ptr_q[p];
    endcase
    we[p] = wr_accept;
    if (rd_advance) addr[d] = ptr_q[d] + 1'b1;
  end

  assign o_addr0 = addr[0];
  assign o_addr1 = addr[1];
  assign o_we0   = we[0];
  assign o_we1   = we[1];
  assign o_wdata = i_write_data;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int b = 0; b < 2; b++) begin
        state_q[b] <= BANK_EMPTY;
        ptr_q[b]   <= '0;
        wcnt_q[b]  <= '0;
        blast_q[b] <= '0;
      end
      sel_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ptr_q   <= ptr_d;
      wcnt_q  <= wcnt_d;
      blast_q <= blast_d;
      sel_q   <= sel_d;
      // Commands other than writes need a bank with data
      err_q   <= (state_q[p] == BANK_EMPTY) && (i_update_length || i_sum_en || i_parser_done);
    end
  end

endmodule

`default_nettype wire

//--- verilog/tx_checksum.sv
/*
  Internet checksum over a word-aligned byte range of the parser bank.
  Reads one word per cycle. Latency is RAM read plus two adder stages.
*/
`timescale 1ns/10ps
`default_nettype none

module tx_checksum
  import tx_buffer_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                   i_clk,
  input  wire                   i_areset,
  input  wire                   i_start,
  input  wire [ADDR_WIDTH-1:0]  i_word_addr,
  input  wire [ADDR_WIDTH+2:0]  i_bytes,
  input  wire                   i_sum_reset,
  input  wire sum_t             i_sum_reset_value,
  input  wire word_t            i_rdata,
  output logic [ADDR_WIDTH-1:0] o_rd_addr,
  output logic                  o_reading,
  output sum_result_t           o_result
);

  logic                  active_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [ADDR_WIDTH+2:0] remain_q;
  logic                  last_word;
  logic [7:0]            mask;

  logic                  rd_v_q, rd_last_q;
  logic [7:0]            rd_mask_q;
  logic                  s0_v_q, s0_last_q;
  sum_t                  psum_q;
  logic [2:0]            carry_q;
  sum_t                  sum_q;
  logic                  done_q;

  word_t                 mword;
  logic [16:0]           add_a, add_b, add_c, add_d, add_e;
  logic [2:0]            carry_cnt;
  sum_t                  sum_next;

  assign last_word = (remain_q <= (ADDR_WIDTH+3)'(BYTES_PER_WORD));
  // A partial last word keeps its leading bytes with bit 7 as the top byte
  assign mask = (last_word && (remain_q[2:0] != 3'd0)) ? ~(8'hff >> remain_q[2:0]) : 8'hff;

  assign o_rd_addr = addr_q;
  assign o_reading = active_q;

  // ------------------------------------------------------------
  // Stage 0 lane tree on the masked word
  // ------------------------------------------------------------

  always_comb begin
    for (int b = 0; b < BYTES_PER_WORD; b++) begin
      mword[b*8 +: 8] = rd_mask_q[b] ? i_rdata[b*8 +: 8] : 8'h00;
    end
  end

  assign add_a = {1'b0, mword[63:48]} + {1'b0, mword[47:32]};
  assign add_b = {1'b0, mword[31:16]} + {1'b0, mword[15:0]};
  assign add_c = {1'b0, add_a[15:0]} + {1'b0, add_b[15:0]};

  // ------------------------------------------------------------
  // Stage 1 end-around carry into the running sum
  // ------------------------------------------------------------

  assign add_d     = {1'b0, sum_q} + {1'b0, psum_q};
  assign carry_cnt = {2'b00, carry_q[0]} + {2'b00, carry_q[1]} +
                     {2'b00, carry_q[2]} + {2'b00, add_d[16]};
  assign add_e     = {1'b0, add_d[15:0]} + {14'd0, carry_cnt};
  assign sum_next  = add_e[16] ? add_e[15:0] + 16'd1 : add_e[15:0];

  assign o_result.sum  = sum_q;
  assign o_result.done = done_q;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      active_q <= 1'b0;
      rd_v_q   <= 1'b0;
      s0_v_q   <= 1'b0;
      sum_q    <= '0;
      done_q   <= 1'b0;
    end else begin
      if (i_start) begin
        active_q <= (i_bytes != '0);
      end else if (active_q && last_word) begin
        active_q <= 1'b0;
      end
      rd_v_q <= active_q;
      s0_v_q <= rd_v_q;
      done_q <= s0_v_q && s0_last_q;
      if (i_sum_reset) begin
        sum_q <= i_sum_reset_value;
      end else if (s0_v_q) begin
        sum_q <= sum_next;
      end
    end
  end

  // Address, count and pipeline payload
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      addr_q   <= i_word_addr;
      remain_q <= i_bytes;
    end else if (active_q) begin
      addr_q   <= addr_q + 1'b1;
      remain_q <= remain_q - (ADDR_WIDTH+3)'(BYTES_PER_WORD);
    end
    rd_mask_q <= mask;
    rd_last_q <= last_word;
    psum_q    <= add_c[15:0];
    carry_q   <= {add_c[16], add_b[16], add_a[16]};
    s0_last_q <= rd_last_q;
  end

endmodule

`default_nettype wire

//--- verilog/tx_buffer.sv
/*
  Double-buffered transmit packet buffer top level.
  Parser fills one bank while the dispatcher drains the other.
*/
`timescale 1ns/10ps
`default_nettype none

module tx_buffer
  import tx_buffer_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                   i_clk,
  input  wire                   i_areset,
  input  wire                   i_write_en,
  input  wire word_t            i_write_data,
  input  wire                   i_update_length,
  input  wire [ADDR_WIDTH+2:0]  i_length_bytes,
  input  wire                   i_sum_en,
  input  wire [ADDR_WIDTH+2:0]  i_sum_addr,
  input  wire [ADDR_WIDTH+2:0]  i_sum_bytes,
  input  wire                   i_sum_reset,
  input  wire sum_t             i_sum_reset_value,
  input  wire                   i_parser_done,
  input  wire                   i_parser_clear,
  input  wire                   i_tx_rd_en,
  input  wire                   i_tx_packet_read,
  output logic                  o_parser_full,
  output logic                  o_parser_empty,
  output tx_status_t            o_tx_status,
  output word_t                 o_tx_rd_data,
  output sum_result_t           o_sum_result,
  output logic                  o_error
);

  logic                  we0, we1;
  logic [ADDR_WIDTH-1:0] addr0, addr1;
  word_t                 wdata, rdata0, rdata1, parser_rdata;
  logic                  sum_start, csum_reading;
  logic [ADDR_WIDTH-1:0] sum_word_addr, csum_addr;
  logic [ADDR_WIDTH+2:0] sum_bytes;

  // ------------------------------------------------------------
  // Word banks
  // ------------------------------------------------------------

  tx_word_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram0 (
    .i_clk  (i_clk),
    .i_we   (we0),
    .i_addr (addr0),
    .i_wdata(wdata),
    .o_rdata(rdata0)
  );

  tx_word_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram1 (
    .i_clk  (i_clk),
    .i_we   (we1),
    .i_addr (addr1),
    .i_wdata(wdata),
    .o_rdata(rdata1)
  );

  tx_bank_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_ctrl (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_write_en      (i_write_en),
    .i_write_data    (i_write_data),
    .i_update_length (i_update_length),
    .i_length_bytes  (i_length_bytes),
    .i_sum_en        (i_sum_en),
    .i_sum_addr      (i_sum_addr),
    .i_sum_bytes     (i_sum_bytes),
    .i_parser_done   (i_parser_done),
    .i_parser_clear  (i_parser_clear),
    .i_tx_rd_en      (i_tx_rd_en),
    .i_tx_packet_read(i_tx_packet_read),
    .i_csum_addr     (csum_addr),
    .i_csum_reading  (csum_reading),
    .i_rdata0        (rdata0),
    .i_rdata1        (rdata1),
    .o_we0           (we0),
    .o_we1           (we1),
    .o_addr0         (addr0),
    .o_addr1         (addr1),
    .o_wdata         (wdata),
    .o_sum_start     (sum_start),
    .o_sum_word_addr (sum_word_addr),
    .o_sum_bytes     (sum_bytes),
    .o_parser_rdata  (parser_rdata),
    .o_parser_full   (o_parser_full),
    .o_parser_empty  (o_parser_empty),
    .o_tx_status     (o_tx_status),
    .o_tx_rd_data    (o_tx_rd_data),
    .o_error         (o_error)
  );

  tx_checksum #(.ADDR_WIDTH(ADDR_WIDTH)) u_csum (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_start          (sum_start),
    .i_word_addr      (sum_word_addr),
    .i_bytes          (sum_bytes),
    .i_sum_reset      (i_sum_reset),
    .i_sum_reset_value(i_sum_reset_value),
    .i_rdata          (parser_rdata),
    .o_rd_addr        (csum_addr),
    .o_reading        (csum_reading),
    .o_result         (o_sum_result)
  );

endmodule

`default_nettype wire

//--- dv/tx_buffer_tb.sv
/*
  Testbench for the transmit packet buffer. Run from the project root so that
  the pattern file is found. Sum ranges in the patterns start on word boundaries.
*/
`timescale 1ns/10ps
`default_nettype none

module tx_buffer_tb
  import tx_buffer_pkg::*;
();

  localparam int ADDR_WIDTH   = 8;
  localparam int CNT_WIDTH    = ADDR_WIDTH + 3;
  localparam int NUM_PATTERNS = 22;
  localparam int MAX_WORDS    = 64;
  localparam int TIMEOUT      = 400;

  logic                 i_clk, i_areset;
  logic                 i_write_en, i_update_length, i_sum_en, i_sum_reset;
  logic                 i_parser_done, i_parser_clear, i_tx_rd_en, i_tx_packet_read;
  word_t                i_write_data;
  logic [CNT_WIDTH-1:0] i_length_bytes, i_sum_addr, i_sum_bytes;
  sum_t                 i_sum_reset_value;
  logic                 o_parser_full, o_parser_empty, o_error;
  tx_status_t           o_tx_status;
  word_t                o_tx_rd_data;
  sum_result_t          o_sum_result;

  // Pattern fields are length, sum start, sum bytes and expected sum
  logic [63:0] patterns [NUM_PATTERNS];
  word_t       pkt_words [2][MAX_WORDS];
  int          pkt_nwords [2];
  bytes_last_t pkt_last [2];
  logic [31:0] rng;

  tx_buffer #(.ADDR_WIDTH(ADDR_WIDTH)) dut_i (.*);

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;

  // ------------------------------------------------------------
  // Reference models
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // End-around carry add
  function automatic sum_t ones_add(input sum_t a, input sum_t b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + {15'd0, s[16]};
  endfunction

  // Byte a of a stored packet with byte 0 in the top of word 0
  function automatic logic [7:0] pkt_byte(input int slot, input int a);
    return pkt_words[slot][a / 8][63 - 8 * (a % 8) -: 8];
  endfunction

  function automatic sum_t model_sum(input int slot, input sum_t start, input int base,
                                     input int nbytes);
    sum_t       acc;
    logic [7:0] lo;
    acc = start;
    for (int k = 0; k < nbytes; k += 2) begin
      // An odd trailing byte is padded with a zero low byte
      lo  = (k + 1 < nbytes) ? pkt_byte(slot, base + k + 1) : 8'h00;
      acc = ones_add(acc, {pkt_byte(slot, base + k), lo});
    end
    return acc;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks and waits
  // ------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t want);
    if (got !== want)
      abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, want));
  endtask

  task automatic check_sum(input string name, input sum_t got, input sum_t want);
    if (got !== want)
      abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, want));
  endtask

  task automatic check_status(input string name, input tx_status_t got, input tx_status_t want);
    if (got !== want)
      abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, want));
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want)
      abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, want));
  endtask

  // Inputs change and outputs are read 1 ns after the edge
  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic wait_sum_done();
    int n;
    n = 0;
    while (!o_sum_result.done) begin
      if (n == TIMEOUT) abort_run("Timeout while waiting for the checksum to finish");
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_available();
    int n;
    n = 0;
    while (!o_tx_status.available) begin
      if (n == TIMEOUT) abort_run("Timeout while waiting for a packet to become available");
      next_cycle();
      n++;
    end
  endtask

  task automatic write_word(input word_t w);
    i_write_en   = 1'b1;
    i_write_data = w;
    next_cycle();
    i_write_en   = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Parser and dispatch sequences
  // ------------------------------------------------------------

  task automatic fill_packet(input int slot, input logic [63:0] pat);
    int   len, sbase, sbytes, nwords;
    sum_t target, data_sum, reset_value, want;
    len    = int'(pat[63:48]);
    sbase  = int'(pat[47:32]);
    sbytes = int'(pat[31:16]);
    target = pat[15:0];
    nwords = (len + 7) / 8;
    if (nwords > MAX_WORDS || sbase % 8 != 0 || sbase + sbytes > nwords * 8)
      abort_run("A pattern line asks for a range outside its packet");
    for (int w = 0; w < nwords; w++) begin
      rng = xorshift32(rng);
      pkt_words[slot][w][63:32] = rng;
      rng = xorshift32(rng);
      pkt_words[slot][w][31:0] = rng;
      write_word(pkt_words[slot][w]);
    end
    pkt_nwords[slot] = nwords;
    pkt_last[slot]   = (len % 8 != 0) ? bytes_last_t'(len % 8) : bytes_last_t'(8);
    i_update_length = 1'b1;
    i_length_bytes  = CNT_WIDTH'(len);
    next_cycle();
    i_update_length = 1'b0;
    // Reset value chosen so the range folds onto the pattern's sum
    data_sum    = model_sum(slot, 16'h0000, sbase, sbytes);
    reset_value = ones_add(target, ~data_sum);
    want        = model_sum(slot, reset_value, sbase, sbytes);
    i_sum_reset       = 1'b1;
    i_sum_reset_value = reset_value;
    next_cycle();
    i_sum_reset = 1'b0;
    i_sum_en    = 1'b1;
    i_sum_addr  = CNT_WIDTH'(sbase);
    i_sum_bytes = CNT_WIDTH'(sbytes);
    next_cycle();
    i_sum_en = 1'b0;
    wait_sum_done();
    check_sum("o_sum_result.sum", o_sum_result.sum, want);
    i_parser_done = 1'b1;
    next_cycle();
    i_parser_done = 1'b0;
    check_flag("o_error", o_error, 1'b0);
  endtask

  task automatic dispatch_packet(input int slot);
    tx_status_t want;
    want.available  = 1'b1;
    want.empty      = 1'b0;
    want.bytes_last = pkt_last[slot];
    check_status("o_tx_status", o_tx_status, want);
    for (int w = 0; w < pkt_nwords[slot]; w++) begin
      check_word("o_tx_rd_data", o_tx_rd_data, pkt_words[slot][w]);
      i_tx_rd_en = 1'b1;
      next_cycle();
    end
    i_tx_rd_en = 1'b0;
    want.empty = 1'b1;
    check_status("o_tx_status", o_tx_status, want);
    i_tx_packet_read = 1'b1;
    next_cycle();
    i_tx_packet_read = 1'b0;
    check_flag("o_tx_status.available", o_tx_status.available, 1'b0);
  endtask

  initial begin
    int slot;
    i_areset          = 1'b1;
    i_write_en        = 1'b0;
    i_write_data      = '0;
    i_update_length   = 1'b0;
    i_length_bytes    = '0;
    i_sum_en          = 1'b0;
    i_sum_addr        = '0;
    i_sum_bytes       = '0;
    i_sum_reset       = 1'b0;
    i_sum_reset_value = '0;
    i_parser_done     = 1'b0;
    i_parser_clear    = 1'b0;
    i_tx_rd_en        = 1'b0;
    i_tx_packet_read  = 1'b0;
    rng               = 32'hcb03_9452;
    $readmemh("dv/tx_buffer_patterns.txt", patterns);
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      if ($isunknown(patterns[i]) || patterns[i][63:48] == 16'd0)
        abort_run("The pattern file is missing or too short");
    end
    repeat (2) @(posedge i_clk);
    #1;
    i_areset = 1'b0;
    next_cycle();

    check_flag("o_parser_empty", o_parser_empty, 1'b1);
    check_flag("o_parser_full", o_parser_full, 1'b0);
    check_flag("o_error", o_error, 1'b0);
    check_flag("o_tx_status.available", o_tx_status.available, 1'b0);
    check_flag("o_sum_result.done", o_sum_result.done, 1'b0);

    // Sum request on an empty bank
    i_sum_en    = 1'b1;
    i_sum_bytes = CNT_WIDTH'(8);
    next_cycle();
    i_sum_en = 1'b0;
    check_flag("o_error", o_error, 1'b1);
    next_cycle();
    check_flag("o_error", o_error, 1'b0);

    // Partial packet dropped by a clear
    write_word(64'hdead_beef_0bad_f00d);
    write_word(64'h0123_4567_89ab_cdef);
    check_flag("o_parser_empty", o_parser_empty, 1'b0);
    i_parser_clear = 1'b1;
    next_cycle();
    i_parser_clear = 1'b0;
    check_flag("o_parser_empty", o_parser_empty, 1'b1);

    for (int i = 0; i < NUM_PATTERNS; i++) begin
      slot = i % 2;
      fill_packet(slot, patterns[i]);
      if (i > 0) begin
        // New packet waits behind the one still held by the dispatcher
        repeat (3) begin
          next_cycle();
          check_flag("o_parser_full", o_parser_full, 1'b1);
        end
        dispatch_packet(1 - slot);
      end
      wait_available();
    end
    dispatch_packet((NUM_PATTERNS - 1) % 2);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tx_buffer_patterns.txt
// length_sum-start_sum-bytes_expected-sum, four 16-bit hex fields per line
// Sum start is a byte address on a word boundary, the range lies inside the packet
0040_0000_0040_1c3a
0021_0008_0019_8f01
0008_0000_0008_0a55
0003_0000_0003_7e12
002e_0010_001d_4b60
0010_0008_0001_0203
0055_0018_0030_c0de
0100_0000_0100_5aa5
0007_0000_0006_e1f0
001f_0000_001f_3344
0048_0020_0027_9abc
0011_0010_0001_0f0f
0080_0040_0040_beef
0009_0000_0009_1357
0039_0008_0031_2468
00ff_0000_00ff_7531
0018_0000_0018_0101
0005_0000_0005_fedc
0030_0028_0008_4000
0068_0000_0067_6e6e
0002_0000_0001_00a1
0028_0000_0028_d00d

//--- sim.f
verilog/tx_buffer_pkg.sv
verilog/tx_word_ram.sv
verilog/tx_bank_ctrl.sv
verilog/tx_checksum.sv
verilog/tx_buffer.sv
dv/tx_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, then run it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --top-module tx_buffer_tb -f sim.f -o tx_buffer_sim &&
  ./obj_dir/tx_buffer_sim ||
  exit 1
